/* run_sim.sh */
#!/bin/sh
# compile and run the pull-then-push server testbench with Verilator
# exit status is 0 only when the testbench reports a pass
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f sources.f --top-module tb_pull_push_server

sim_status=0
sim_out=$(./obj_dir/Vtb_pull_push_server 2>&1) || sim_status=$?
echo "$sim_out"

if echo "$sim_out" | grep -qx "TEST PASS"; then
  exit 0
else
  echo "simulation exit status: $sim_status"
  exit 1
fi

/* sources.f */
src/pollsrv_pkg.sv
src/cmd_poller.sv
src/rsp_fifo.sv
src/rsp_pusher.sv
src/pull_push_server.sv
tests/tb_pull_push_server.sv

/* src/cmd_poller.sv */
// ################################################
// poll scheduler with adaptive backoff; strobes the
// host for a command, offers a hit to the client and
// waits for the client response before polling again
// ################################################

`timescale 1ns/1ps

module cmd_poller import pollsrv_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  // host pull side
  output logic                       host_pull_req,
  input  logic                       host_cmd_vld,
  input  logic [PULL_DATA_WIDTH-1:0] host_cmd_data,
  // client pull side
  output logic                       pull_data_vld,
  output logic [PULL_DATA_WIDTH-1:0] pull_data,
  input  logic                       pull_data_rdy,
  // response handshake with the top level
  output logic                       rsp_wanted,
  input  logic                       rsp_accept
);

  poller_state_t state;

  // cycles left in POLL_WAIT
  logic [DELAY_WIDTH-1:0] wait_cnt;
  // delay used for the last wait, base of the backoff
  logic [DELAY_WIDTH-1:0] last_delay;
  // delay to use after a miss
  logic [DELAY_WIDTH-1:0] next_delay;

  // backoff rule
  // zero grows to one and anything else is quadrupled
  // and clipped at the inactive ceiling
  function automatic logic [DELAY_WIDTH-1:0] backoff(input logic [DELAY_WIDTH-1:0] prev);
    logic [DELAY_WIDTH+1:0] grown;
    grown = {prev, 2'b00};
    if (prev == '0) begin
      return DELAY_WIDTH'(1);
    end
    if (grown > {2'b00, DELAY_INACTIVE}) begin
      return DELAY_INACTIVE;
    end
    return grown[DELAY_WIDTH-1:0];
  endfunction

  assign next_delay = backoff(last_delay);

  // strobe lasts exactly the single POLL_ISSUE cycle
  assign host_pull_req = (state == POLL_ISSUE);
  assign pull_data_vld = (state == CMD_OFFER);
  assign rsp_wanted    = (state == RSP_AWAIT);

  always_ff @(posedge clk) begin
    if (reset) begin
      // poll right away after reset with no delay history
      state      <= POLL_ISSUE;
      wait_cnt   <= '0;
      last_delay <= '0;
    end else begin
      case (state)
        POLL_WAIT: begin
          // counter is loaded with d so d wait cycles pass
          if (wait_cnt == DELAY_WIDTH'(1)) begin
            state <= POLL_ISSUE;
          end
          wait_cnt <= wait_cnt - DELAY_WIDTH'(1);
        end
        POLL_ISSUE: begin
          if (host_cmd_vld) begin
            // a hit makes the next wait the active one
            state      <= CMD_OFFER;
            last_delay <= DELAY_ACTIVE;
          end else begin
            // a miss backs off further
            state      <= POLL_WAIT;
            last_delay <= next_delay;
            wait_cnt   <= next_delay;
          end
        end
        CMD_OFFER: begin
          // client took the command
          if (pull_data_rdy) begin
            state <= RSP_AWAIT;
          end
        end
        RSP_AWAIT: begin
          // response is in the buffer though the host may still be busy
          if (rsp_accept) begin
            state    <= POLL_WAIT;
            wait_cnt <= DELAY_ACTIVE;
          end
        end
        default: begin
          state <= POLL_ISSUE;
        end
      endcase
    end
  end

  // command captured on a hit and held through the offer
  always_ff @(posedge clk) begin
    if (host_pull_req && host_cmd_vld) begin
      pull_data <= host_cmd_data;
    end
  end

  // offered command must not move under a stalled client
  assert property (@(posedge clk) disable iff (reset)
    pull_data_vld && !pull_data_rdy |=> pull_data_vld && $stable(pull_data))
    else $error("pull_data changed while waiting for pull_data_rdy");

  // pull strobe never lasts two cycles in a row
  assert property (@(posedge clk) disable iff (reset)
    host_pull_req |=> !host_pull_req)
    else $error("host_pull_req is not a single-cycle pulse");

endmodule

/* src/pollsrv_pkg.sv */
// ################################################
// shared widths, backoff constants, buffer depth
// and state encodings for the polled pull-then-push
// server; import into any module that needs them
// ################################################

package pollsrv_pkg;

  // command and response payload widths
  localparam int PULL_DATA_WIDTH = 64;
  localparam int PUSH_DATA_WIDTH = 64;

  // delay counter width, wide enough for the backoff ceiling
  localparam int DELAY_WIDTH = 8;

  // backoff ceiling while the host has nothing to give
  localparam logic [DELAY_WIDTH-1:0] DELAY_INACTIVE = DELAY_WIDTH'(200);

  // short wait once a transaction went through
  localparam logic [DELAY_WIDTH-1:0] DELAY_ACTIVE = DELAY_WIDTH'(4);

  // response buffer geometry
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_AW = 2;

  // poller FSM
  // wait out the delay, strobe the host, offer the command,
  // then hold until the client response is taken
  typedef enum logic [1:0] {
    POLL_WAIT  = 2'd0,
    POLL_ISSUE = 2'd1,
    CMD_OFFER  = 2'd2,
    RSP_AWAIT  = 2'd3
  } poller_state_t;

  // pusher FSM
  // idle until a response is buffered, then hold it
  // on the host port until acknowledged
  typedef enum logic {
    PUSH_IDLE = 1'b0,
    PUSH_HOLD = 1'b1
  } pusher_state_t;

endpackage

/* src/pull_push_server.sv */
// ################################################
// polled pull-then-push server; host commands go to
// the client, client responses are buffered and
// pushed back to the host over strobe ports
// ################################################

`timescale 1ns/1ps

module pull_push_server import pollsrv_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  // host pull
  output logic                       host_pull_req,
  input  logic                       host_cmd_vld,
  input  logic [PULL_DATA_WIDTH-1:0] host_cmd_data,
  // client pull
  output logic                       pull_data_vld,
  output logic [PULL_DATA_WIDTH-1:0] pull_data,
  input  logic                       pull_data_rdy,
  // client push
  output logic                       push_data_rdy,
  input  logic                       push_data_vld,
  input  logic [PUSH_DATA_WIDTH-1:0] push_data,
  // host push
  output logic                       host_push_vld,
  output logic [PUSH_DATA_WIDTH-1:0] host_push_data,
  input  logic                       host_push_ack
);

  logic                       rsp_wanted;
  logic                       rsp_accept;
  logic                       fifo_full;
  logic                       fifo_empty;
  logic                       fifo_pop;
  logic [PUSH_DATA_WIDTH-1:0] fifo_head;

  // client may push only when the poller waits and there is room
  assign push_data_rdy = rsp_wanted && !fifo_full;
  // single-cycle transfer, feeds buffer write and poller
  assign rsp_accept    = push_data_rdy && push_data_vld;

  cmd_poller u_poller (
    .clk           (clk),
    .reset         (reset),
    .host_pull_req (host_pull_req),
    .host_cmd_vld  (host_cmd_vld),
    .host_cmd_data (host_cmd_data),
    .pull_data_vld (pull_data_vld),
    .pull_data     (pull_data),
    .pull_data_rdy (pull_data_rdy),
    .rsp_wanted    (rsp_wanted),
    .rsp_accept    (rsp_accept)
  );

  rsp_fifo u_fifo (
    .clk     (clk),
    .reset   (reset),
    .wr_en   (rsp_accept),
    .wr_data (push_data),
    .rd_en   (fifo_pop),
    .rd_data (fifo_head),
    .empty   (fifo_empty),
    .full    (fifo_full)
  );

  rsp_pusher u_pusher (
    .clk            (clk),
    .reset          (reset),
    .fifo_empty     (fifo_empty),
    .fifo_head      (fifo_head),
    .fifo_pop       (fifo_pop),
    .host_push_vld  (host_push_vld),
    .host_push_data (host_push_data),
    .host_push_ack  (host_push_ack)
  );

endmodule

/* src/rsp_fifo.sv */
// ################################################
// circular buffer for client responses on their way
// to the host; head word is shown without a read
// cycle and rd_en pops it
// ################################################

`timescale 1ns/1ps

module rsp_fifo import pollsrv_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  // write side from the client push
  input  logic                       wr_en,
  input  logic [PUSH_DATA_WIDTH-1:0] wr_data,
  // read side to the pusher
  input  logic                       rd_en,
  output logic [PUSH_DATA_WIDTH-1:0] rd_data,
  output logic                       empty,
  output logic                       full
);

  // response storage
  logic [PUSH_DATA_WIDTH-1:0] mem [FIFO_DEPTH];

  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  // occupancy is one bit wider than the pointers
  logic [FIFO_AW:0]   count;

  assign empty   = (count == '0);
  assign full    = (count == (FIFO_AW+1)'(FIFO_DEPTH));
  assign rd_data = mem[rd_ptr];

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap naturally since the depth is a power of two
      if (wr_en) begin
        wr_ptr <= wr_ptr + FIFO_AW'(1);
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + FIFO_AW'(1);
      end
      // simultaneous write and read keeps the count
      case ({wr_en, rd_en})
        2'b10:   count <= count + (FIFO_AW+1)'(1);
        2'b01:   count <= count - (FIFO_AW+1)'(1);
        default: count <= count;
      endcase
    end
  end

  // data write
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // top level must keep push_data_rdy low when full
  assert property (@(posedge clk) disable iff (reset) wr_en |-> !full)
    else $error("response written into a full buffer");

  // pusher must only pop a buffered response
  assert property (@(posedge clk) disable iff (reset) rd_en |-> !empty)
    else $error("response popped from an empty buffer");

endmodule

/* src/rsp_pusher.sv */
// ################################################
// drains the response buffer to the host; each word
// is popped, registered and held on the host port
// until host_push_ack, two cycles per word at best
// ################################################

`timescale 1ns/1ps

module rsp_pusher import pollsrv_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  // buffer side
  input  logic                       fifo_empty,
  input  logic [PUSH_DATA_WIDTH-1:0] fifo_head,
  output logic                       fifo_pop,
  // host push side
  output logic                       host_push_vld,
  output logic [PUSH_DATA_WIDTH-1:0] host_push_data,
  input  logic                       host_push_ack
);

  pusher_state_t state;

  // pop in the same cycle the head is registered
  assign fifo_pop      = (state == PUSH_IDLE) && !fifo_empty;
  assign host_push_vld = (state == PUSH_HOLD);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= PUSH_IDLE;
    end else begin
      case (state)
        PUSH_IDLE: begin
          if (!fifo_empty) begin
            state <= PUSH_HOLD;
          end
        end
        PUSH_HOLD: begin
          // every response is held, none is dropped
          if (host_push_ack) begin
            state <= PUSH_IDLE;
          end
        end
        default: begin
          state <= PUSH_IDLE;
        end
      endcase
    end
  end

  // response word, loaded on pop
  always_ff @(posedge clk) begin
    if (fifo_pop) begin
      host_push_data <= fifo_head;
    end
  end

  // host sees a steady word until it acknowledges
  assert property (@(posedge clk) disable iff (reset)
    host_push_vld && !host_push_ack |=> host_push_vld && $stable(host_push_data))
    else $error("host_push_data changed before host_push_ack");

endmodule

/* tests/tb_pull_push_server.sv */
// ##################################################
// testbench for the pull-then-push server; random
// host and client models from a fixed seed drive the
// DUT and a model of the poll schedule and the data
// queues checks every transfer and every poll gap
// ##################################################

`timescale 1ns/1ps

module tb_pull_push_server import pollsrv_pkg::*; ();

  // responses the host takes before the run ends
  localparam int TXN_COUNT = 150;
  // host responses taken before the host stalls
  localparam int BP_START = 100;
  // cycles the full buffer is watched under a stalled host
  localparam int BP_HOLD = 50;
  // miss gaps walked from reset up to the ceiling and past it
  localparam int MISS_GAPS = 6;
  // every transaction may sit out about two ceiling waits before its hit
  localparam int CYCLE_LIMIT = (TXN_COUNT + MISS_GAPS + 2) * 2 * (int'(DELAY_INACTIVE) + 1);
  // largest gap count that still fits the delay compare
  localparam int GAP_MAX = (1 << DELAY_WIDTH) - 1;

  typedef enum int {
    PH_MISS,
    PH_TRAFFIC,
    PH_BACKPRESSURE,
    PH_DRAIN
  } tb_phase_t;

  logic                       clk = 1'b0;
  logic                       reset = 1'b1;
  logic                       host_pull_req;
  logic                       host_cmd_vld = 1'b0;
  logic [PULL_DATA_WIDTH-1:0] host_cmd_data = '0;
  logic                       pull_data_vld;
  logic [PULL_DATA_WIDTH-1:0] pull_data;
  logic                       pull_data_rdy = 1'b0;
  logic                       push_data_rdy;
  logic                       push_data_vld = 1'b0;
  logic [PUSH_DATA_WIDTH-1:0] push_data = '0;
  logic                       host_push_vld;
  logic [PUSH_DATA_WIDTH-1:0] host_push_data;
  logic                       host_push_ack = 1'b0;

  integer seed = 32'hfe12ab25;

  // commands handed out by the host, in order
  logic [PULL_DATA_WIDTH-1:0] cmd_q[$];
  // responses the host should see, in order
  logic [PUSH_DATA_WIDTH-1:0] rsp_q[$];
  logic [PULL_DATA_WIDTH-1:0] exp_cmd;
  logic [PUSH_DATA_WIDTH-1:0] exp_rsp;

  // poll schedule model
  logic [DELAY_WIDTH-1:0] model_delay;
  logic [DELAY_WIDTH-1:0] exp_gap;
  int                     gap_cnt;
  bit                     gap_armed;
  int                     miss_gaps;

  // client model
  bit                         client_busy;
  int                         client_gap;
  logic [PUSH_DATA_WIDTH-1:0] client_rsp;

  // stall history for the hold checks
  bit                         pull_stall;
  logic [PULL_DATA_WIDTH-1:0] pull_prev;
  bit                         push_stall;
  logic [PUSH_DATA_WIDTH-1:0] push_prev;

  tb_phase_t phase;
  int        host_taken;
  int        in_flight;
  int        hold_cnt;
  int        cycle_cnt;
  bit        first_cycle;
  bit        done = 1'b0;

  pull_push_server uut (
    .clk            (clk),
    .reset          (reset),
    .host_pull_req  (host_pull_req),
    .host_cmd_vld   (host_cmd_vld),
    .host_cmd_data  (host_cmd_data),
    .pull_data_vld  (pull_data_vld),
    .pull_data      (pull_data),
    .pull_data_rdy  (pull_data_rdy),
    .push_data_rdy  (push_data_rdy),
    .push_data_vld  (push_data_vld),
    .push_data      (push_data),
    .host_push_vld  (host_push_vld),
    .host_push_data (host_push_data),
    .host_push_ack  (host_push_ack)
  );

  // 100 ns clock
  always #50 clk = ~clk;

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % $unsigned(n));
  endfunction

  // wait after a miss goes from zero to one or else four times up to the ceiling
  function automatic logic [DELAY_WIDTH-1:0] next_backoff(input logic [DELAY_WIDTH-1:0] prev);
    int grown;
    grown = int'(prev) * 4;
    if (prev == '0) begin
      return DELAY_WIDTH'(1);
    end
    if (grown > int'(DELAY_INACTIVE)) begin
      return DELAY_INACTIVE;
    end
    return DELAY_WIDTH'(grown);
  endfunction

  task automatic stop_failed();
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    $display("Error at %0t: %s", $time, msg);
    stop_failed();
  endtask

  task automatic check_cmd(input logic [PULL_DATA_WIDTH-1:0] got,
                           input logic [PULL_DATA_WIDTH-1:0] exp, input string what);
    if (got !== exp) begin
      $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
      stop_failed();
    end
  endtask

  task automatic check_rsp(input logic [PUSH_DATA_WIDTH-1:0] got,
                           input logic [PUSH_DATA_WIDTH-1:0] exp, input string what);
    if (got !== exp) begin
      $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
      stop_failed();
    end
  endtask

  task automatic check_delay(input logic [DELAY_WIDTH-1:0] got,
                             input logic [DELAY_WIDTH-1:0] exp, input string what);
    if (got !== exp) begin
      $display("Fail %0t: %s got %0d expected %0d", $time, what, got, exp);
      stop_failed();
    end
  endtask

  // host and client models with checks on the values seen before this edge
  always @(posedge clk) begin
    if (reset) begin
      host_cmd_vld  <= 1'b0;
      host_cmd_data <= {$random(seed), $random(seed)};
      pull_data_rdy <= 1'b0;
      push_data_vld <= 1'b0;
      host_push_ack <= 1'b0;
      model_delay   = '0;
      gap_armed     = 1'b0;
      miss_gaps     = 0;
      client_busy   = 1'b0;
      pull_stall    = 1'b0;
      push_stall    = 1'b0;
      phase         = PH_MISS;
      host_taken    = 0;
      in_flight     = 0;
      hold_cnt      = 0;
      cycle_cnt     = 0;
      first_cycle   = 1'b1;
    end else begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT) begin
        $display("simulation timed out after %0d cycles", cycle_cnt);
        stop_failed();
      end
      if (first_cycle) begin
        if (pull_data_vld || push_data_rdy || host_push_vld) begin
          report_error("handshake outputs are not low after reset");
        end
        if (!host_pull_req) begin
          report_error("no pull request in the first cycle after reset");
        end
        first_cycle = 1'b0;
      end
      // offered command and pushed response hold while stalled
      if (pull_stall) begin
        if (!pull_data_vld) begin
          report_error("pull_data_vld dropped before pull_data_rdy");
        end
        check_cmd(pull_data, pull_prev, "held pull_data");
      end
      if (push_stall) begin
        if (!host_push_vld) begin
          report_error("host_push_vld dropped before host_push_ack");
        end
        check_rsp(host_push_data, push_prev, "held host_push_data");
      end
      // buffer holds what was accepted minus the word held by the pusher
      if (push_data_rdy && (in_flight - (host_push_vld ? 1 : 0)) >= FIFO_DEPTH) begin
        report_error("push_data_rdy is high while the response buffer is full");
      end
      // poll schedule
      if (host_pull_req) begin
        if (gap_armed) begin
          check_delay(DELAY_WIDTH'(gap_cnt), exp_gap, "poll gap");
          if (phase == PH_MISS) begin
            miss_gaps = miss_gaps + 1;
          end
        end
        gap_armed = 1'b0;
        if (host_cmd_vld) begin
          cmd_q.push_back(host_cmd_data);
          model_delay = DELAY_ACTIVE;
          host_cmd_data <= {$random(seed), $random(seed)};
        end else begin
          model_delay = next_backoff(model_delay);
          exp_gap   = model_delay;
          gap_cnt   = 0;
          gap_armed = 1'b1;
        end
      end else if (gap_armed && gap_cnt < GAP_MAX) begin
        // count stops above every legal delay so a long gap never wraps
        gap_cnt = gap_cnt + 1;
      end
      // client takes a command and prepares the inverted response
      if (pull_data_vld && pull_data_rdy) begin
        if (cmd_q.size() == 0) begin
          report_error("client received a command the host never handed out");
        end
        exp_cmd = cmd_q.pop_front();
        check_cmd(pull_data, exp_cmd, "command to client");
        rsp_q.push_back(~exp_cmd);
        client_rsp  = ~pull_data;
        client_gap  = rand_below(4);
        client_busy = 1'b1;
      end
      // the next poll is timed from the client push accept
      if (push_data_vld && push_data_rdy) begin
        push_data_vld <= 1'b0;
        in_flight = in_flight + 1;
        exp_gap   = DELAY_ACTIVE;
        gap_cnt   = 0;
        gap_armed = 1'b1;
      end else if (client_busy) begin
        if (client_gap == 0) begin
          push_data_vld <= 1'b1;
          push_data     <= client_rsp;
          client_busy = 1'b0;
        end else begin
          client_gap = client_gap - 1;
        end
      end
      // host takes a response
      if (host_push_vld && host_push_ack) begin
        if (rsp_q.size() == 0) begin
          report_error("host received a response with none outstanding");
        end
        exp_rsp = rsp_q.pop_front();
        check_rsp(host_push_data, exp_rsp, "response to host");
        host_taken = host_taken + 1;
        in_flight  = in_flight - 1;
      end
      pull_stall = pull_data_vld && !pull_data_rdy;
      pull_prev  = pull_data;
      push_stall = host_push_vld && !host_push_ack;
      push_prev  = host_push_data;
      // traffic phases
      case (phase)
        PH_MISS: begin
          host_cmd_vld <= 1'b0;
          if (miss_gaps == MISS_GAPS) begin
            phase = PH_TRAFFIC;
          end
        end
        PH_TRAFFIC: begin
          host_cmd_vld  <= (rand_below(10) < 4);
          host_push_ack <= (rand_below(2) == 0);
          if (host_taken >= BP_START) begin
            phase = PH_BACKPRESSURE;
          end
        end
        PH_BACKPRESSURE: begin
          // host stalls so buffer and pusher fill up
          host_cmd_vld  <= (rand_below(10) < 4);
          host_push_ack <= 1'b0;
          if (in_flight > FIFO_DEPTH + 1) begin
            report_error("more responses accepted than buffer and pusher can hold");
          end
          if (in_flight == FIFO_DEPTH + 1) begin
            hold_cnt = hold_cnt + 1;
          end
          if (hold_cnt == BP_HOLD) begin
            phase = PH_DRAIN;
          end
        end
        default: begin
          host_cmd_vld  <= (rand_below(10) < 4);
          host_push_ack <= (rand_below(2) == 0);
          if (host_taken >= TXN_COUNT) begin
            done = 1'b1;
          end
        end
      endcase
      pull_data_rdy <= (rand_below(2) == 0);
    end
  end

  initial begin
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    wait (done);
    $display("%0d responses checked in %0d cycles", host_taken, cycle_cnt);
    $display("TEST PASS");
    $finish;
  end

endmodule
